/* design/smc_defs.svh */
// Bank count and fixed chip-select timings, included wherever widths or timings are needed
`ifndef SMC_DEFS_SVH
`define SMC_DEFS_SVH

// ------------------------------------------------------------
// Bank decode
// ------------------------------------------------------------
`define SMC_NUM_BANKS     2   // Chip selects on the memory bus
`define SMC_BANK_SEL_BIT  15  // Host address bit picking the bank

// ------------------------------------------------------------
// Bank 0, fast part
// ------------------------------------------------------------
`define SMC_B0_CSLE  0  // Leading-edge cycles
`define SMC_B0_WS    1  // Wait states, strobe is ws+1 wide
`define SMC_B0_OETE  0  // Read sample point before strobe end
`define SMC_B0_CSTE  0  // Trailing-edge (float) cycles

// ------------------------------------------------------------
// Bank 1, slow part
// ------------------------------------------------------------
`define SMC_B1_CSLE  2
`define SMC_B1_WS    4
`define SMC_B1_OETE  1
`define SMC_B1_CSTE  2

`endif

/* design/smc_pkg.sv */
// Shared types of the static memory controller, referenced by scoped name from RTL and testbench
package smc_pkg;

  // ------------------------------------------------------------
  // Access FSM, one-hot
  // ------------------------------------------------------------
  typedef enum logic [4:0]
  {
    st_idle  = 5'b00001,  // No access running
    st_store = 5'b00010,  // Timings loaded, CS still high
    st_le    = 5'b00100,  // CS low, strobes high
    st_rw    = 5'b01000,  // Strobe low
    st_float = 5'b10000   // CS low after strobe
  } smc_state_e;

  // ------------------------------------------------------------
  // Widths that carry a meaning
  // ------------------------------------------------------------
  typedef logic [7:0]  ws_count_t;    // Wait-state count
  typedef logic [1:0]  edge_count_t;  // LE, TE and OE-end counts
  typedef logic [15:0] host_addr_t;   // Host byte address
  typedef logic [31:0] host_data_t;   // Host data word
  typedef logic [7:0]  mem_data_t;    // External data byte
  typedef logic [1:0]  xfer_size_t;   // 0 byte, 1 half, 2 word
  typedef logic        bank_t;        // Chip-select index

endpackage

/* design/smc_access_if.sv */
// Access description passed from the decoder to the execute and result stages
`include "smc_defs.svh"

interface smc_access_if;

  logic                         new_access;  // Request pending, not yet taken
  logic                         n_read;      // Pending direction, low for read
  logic                         n_r_read;    // Direction of running access
  logic [`SMC_NUM_BANKS-1:0]    cs;          // Pending bank, one-hot
  smc_pkg::bank_t               r_cs;        // Bank of running access
  smc_pkg::edge_count_t         csle_store;  // Stored timings of running access
  smc_pkg::ws_count_t           ws_store;
  smc_pkg::edge_count_t         oete_store;
  smc_pkg::edge_count_t         cste_store;
  smc_pkg::host_addr_t          addr;        // Base address of running access
  smc_pkg::xfer_size_t          size;
  smc_pkg::host_data_t          wdata;

  modport decode
  (
    output new_access, n_read, n_r_read, cs, r_cs,
    output csle_store, ws_store, oete_store, cste_store,
    output addr, size, wdata
  );

  modport execute
  (
    input new_access, n_read, n_r_read, cs, r_cs,
    input csle_store, ws_store, oete_store, cste_store
  );

  modport result
  (
    input n_r_read, r_cs, addr, size, wdata
  );

endinterface

/* design/smc_access_decode.sv */
// Decode stage, holds off the host request and loads bank, direction and timings on accept
`include "smc_defs.svh"

module smc_access_decode
(
  input  logic                 sys_clk30,
  input  logic                 n_sys_reset30,
  input  logic                 req,
  input  logic                 write,
  input  smc_pkg::host_addr_t  addr,
  input  smc_pkg::xfer_size_t  size,
  input  smc_pkg::host_data_t  wdata,
  input  logic                 valid_access,
  smc_access_if.decode         acc
);

  logic                  r_accepted;  // Accept seen last cycle
  smc_pkg::bank_t        bank;        // Bank of pending request
  smc_pkg::edge_count_t  csle;
  smc_pkg::ws_count_t    ws;
  smc_pkg::edge_count_t  oete;
  smc_pkg::edge_count_t  cste;

  assign bank = addr[`SMC_BANK_SEL_BIT];

  // Host still holds the old request until the falling edge after accept
  assign acc.new_access = req & ~r_accepted;
  assign acc.n_read     = write;  // Low means read

  always_comb
  begin
    acc.cs       = '0;
    acc.cs[bank] = 1'b1;
  end

  // ------------------------------------------------------------
  // Bank timing lookup
  // ------------------------------------------------------------
  always_comb
  begin
    if (bank == 1'b0)
    begin
      csle = smc_pkg::edge_count_t'(`SMC_B0_CSLE);
      ws   = smc_pkg::ws_count_t'(`SMC_B0_WS);
      oete = smc_pkg::edge_count_t'(`SMC_B0_OETE);
      cste = smc_pkg::edge_count_t'(`SMC_B0_CSTE);
    end
    else
    begin
      csle = smc_pkg::edge_count_t'(`SMC_B1_CSLE);
      ws   = smc_pkg::ws_count_t'(`SMC_B1_WS);
      oete = smc_pkg::edge_count_t'(`SMC_B1_OETE);
      cste = smc_pkg::edge_count_t'(`SMC_B1_CSTE);
    end
    // Zero-lead bank gets one float cycle so adjacent strobes stay apart
    if (csle == 2'd0 && cste == 2'd0)
      cste = 2'd1;
  end

  always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
  begin
    if (!n_sys_reset30)
    begin
      r_accepted   <= 1'b0;
      acc.n_r_read <= 1'b0;
      acc.r_cs     <= 1'b0;
    end
    else
    begin
      r_accepted <= valid_access;
      if (valid_access)
      begin
        acc.n_r_read <= write;
        acc.r_cs     <= bank;
      end
    end
  end

  // Held for the whole access
  always_ff @(posedge sys_clk30)
  begin
    if (valid_access)
    begin
      acc.csle_store <= csle;
      acc.ws_store   <= ws;
      acc.oete_store <= oete;
      acc.cste_store <= cste;
      acc.addr       <= addr;
      acc.size       <= size;
      acc.wdata      <= wdata;
    end
  end

endmodule

/* design/smc_counters.sv */
// Execute-side leading-edge, wait-state and trailing-edge counters driven by the access FSM
module smc_counters
(
  input  logic                  sys_clk30,
  input  logic                  n_sys_reset30,
  smc_access_if.execute         acc,
  input  logic                  le_enable,
  input  logic                  ws_enable,
  input  logic                  cste_enable,
  input  logic                  valid_access,
  output smc_pkg::edge_count_t  r_csle_count,
  output smc_pkg::edge_count_t  r_cste_count,
  output smc_pkg::ws_count_t    r_ws_count
);

  // Edge counters hold span-1 on entry and reach zero in the last cycle
  function automatic smc_pkg::edge_count_t edge_next
  (
    input logic                  en,
    input logic                  restart,
    input smc_pkg::edge_count_t  count,
    input smc_pkg::edge_count_t  span
  );
    if (!en)
      return '0;                 // Idle value, ready for next load
    else if (count == 2'd0 || restart)
      return span - 2'd1;
    else
      return count - 2'd1;
  endfunction

  // ------------------------------------------------------------
  // Counter registers
  // ------------------------------------------------------------
  always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
  begin
    if (!n_sys_reset30)
    begin
      r_csle_count <= '0;
      r_cste_count <= '0;
      r_ws_count   <= '0;
    end
    else
    begin
      // Reloaded on every beat from the stored bank timing
      r_csle_count <= edge_next(le_enable, valid_access, r_csle_count, acc.csle_store);
      r_cste_count <= edge_next(cste_enable, valid_access, r_cste_count, acc.cste_store);

      if (!ws_enable)
        r_ws_count <= '0;
      else if (r_ws_count == 8'd0 || valid_access)
        r_ws_count <= acc.ws_store;  // Strobe start, also RW to RW
      else
        r_ws_count <= r_ws_count - 8'd1;
    end
  end

endmodule

/* design/smc_state.sv */
// Access FSM, sequences store, leading edge, strobe and float phases and accepts back-to-back
module smc_state
(
  input  logic                  sys_clk30,
  input  logic                  n_sys_reset30,
  smc_access_if.execute         acc,
  input  smc_pkg::edge_count_t  r_csle_count,
  input  smc_pkg::edge_count_t  r_cste_count,
  input  smc_pkg::ws_count_t    r_ws_count,
  input  logic                  mac_done,
  output smc_pkg::smc_state_e   r_smc_currentstate,
  output smc_pkg::smc_state_e   smc_nextstate,
  output logic                  cste_enable,
  output logic                  ws_enable,
  output logic                  le_enable,
  output logic                  smc_done,
  output logic                  valid_access,
  output logic                  latch_data,
  output logic                  smc_idle
);

  smc_pkg::smc_state_e  first_phase;  // Where a beat begins
  smc_pkg::smc_state_e  beat_next;    // Where the last beat cycle goes
  logic                 change;       // Pending access needs a store cycle

  // ------------------------------------------------------------
  // Phase decodes
  // ------------------------------------------------------------
  assign smc_idle = (smc_nextstate == smc_pkg::st_idle);

  // Last cycle of a beat, in RW when there is no float
  assign smc_done = ((r_smc_currentstate == smc_pkg::st_rw) &&
                     (r_ws_count == 8'd0) && (acc.cste_store == 2'd0)) ||
                    ((r_smc_currentstate == smc_pkg::st_float) &&
                     (r_cste_count == 2'd0));

  // Read byte sampled oete cycles before the strobe ends
  assign latch_data = (r_smc_currentstate == smc_pkg::st_rw) &&
                      (r_ws_count == smc_pkg::ws_count_t'(acc.oete_store));

  // Counters run while the FSM heads into their phase
  assign le_enable   = (smc_nextstate == smc_pkg::st_le);
  assign ws_enable   = (smc_nextstate == smc_pkg::st_rw);
  assign cste_enable = (smc_nextstate == smc_pkg::st_float);

  // New request taken from idle or on the final beat's done
  assign valid_access = acc.new_access &&
                        ((r_smc_currentstate == smc_pkg::st_idle) ||
                         (smc_done && mac_done));

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  assign change = (acc.n_read != acc.n_r_read) || !acc.cs[acc.r_cs];

  always_comb
  begin
    first_phase = (acc.csle_store != 2'd0) ? smc_pkg::st_le : smc_pkg::st_rw;

    if (!mac_done)
      beat_next = first_phase;                      // Next byte, skips store
    else if (acc.new_access)
      beat_next = change ? smc_pkg::st_store : first_phase;  // Bypass idle
    else
      beat_next = smc_pkg::st_idle;
  end

  always_comb
  begin
    case (r_smc_currentstate)
      smc_pkg::st_idle:
        smc_nextstate = acc.new_access ? smc_pkg::st_store : smc_pkg::st_idle;

      smc_pkg::st_store:
        smc_nextstate = first_phase;

      smc_pkg::st_le:
        smc_nextstate = (r_csle_count == 2'd0) ? smc_pkg::st_rw : smc_pkg::st_le;

      smc_pkg::st_rw:
      begin
        if (r_ws_count != 8'd0)
          smc_nextstate = smc_pkg::st_rw;           // Strobe still held
        else if (acc.cste_store != 2'd0)
          smc_nextstate = smc_pkg::st_float;
        else
          smc_nextstate = beat_next;
      end

      smc_pkg::st_float:
        smc_nextstate = (r_cste_count != 2'd0) ? smc_pkg::st_float : beat_next;

      default:
        smc_nextstate = smc_pkg::st_idle;
    endcase
  end

  always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
  begin
    if (!n_sys_reset30)
      r_smc_currentstate <= smc_pkg::st_idle;
    else
      r_smc_currentstate <= smc_nextstate;
  end

endmodule

/* design/smc_mac_data.sv */
// Result stage, steps byte beats, drives the memory pins and assembles the host read word
`include "smc_defs.svh"

module smc_mac_data
(
  input  logic                       sys_clk30,
  input  logic                       n_sys_reset30,
  smc_access_if.result               acc,
  input  smc_pkg::smc_state_e        r_smc_currentstate,
  input  logic                       smc_done,
  input  logic                       latch_data,
  input  logic                       valid_access,
  output logic                       mac_done,
  output logic                       done,
  output smc_pkg::host_data_t        rdata,
  output logic [`SMC_NUM_BANKS-1:0]  n_mem_cs,
  output logic                       n_mem_oe,
  output logic                       n_mem_we,
  output logic                       mem_wdata_en,
  output smc_pkg::host_addr_t        mem_addr,
  output smc_pkg::mem_data_t         mem_wdata,
  input  smc_pkg::mem_data_t         mem_rdata
);

  logic [1:0]  r_beat;     // Byte beat in the transfer
  logic [1:0]  last_beat;
  logic        cs_active;  // Past store, CS driven
  logic        strobe;

  always_comb
  begin
    case (acc.size)
      2'd0:    last_beat = 2'd0;
      2'd1:    last_beat = 2'd1;
      default: last_beat = 2'd3;
    endcase
  end

  assign mac_done = (r_beat == last_beat);

  always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
  begin
    if (!n_sys_reset30)
    begin
      r_beat <= 2'd0;
      done   <= 1'b0;
    end
    else
    begin
      if (valid_access)
        r_beat <= 2'd0;
      else if (smc_done)
        r_beat <= r_beat + 2'd1;
      done <= smc_done & mac_done;  // One cycle after final beat
    end
  end

  // Read bytes land in lane order
  always_ff @(posedge sys_clk30)
  begin
    if (latch_data && !acc.n_r_read)
      rdata[{r_beat, 3'b000} +: 8] <= mem_rdata;
  end

  // ------------------------------------------------------------
  // External pins
  // ------------------------------------------------------------
  assign mem_addr  = acc.addr + smc_pkg::host_addr_t'(r_beat);
  assign mem_wdata = acc.wdata[{r_beat, 3'b000} +: 8];

  assign cs_active = (r_smc_currentstate != smc_pkg::st_idle) &&
                     (r_smc_currentstate != smc_pkg::st_store);
  assign strobe    = (r_smc_currentstate == smc_pkg::st_rw);

  always_comb
  begin
    n_mem_cs = '1;
    if (cs_active)
      n_mem_cs[acc.r_cs] = 1'b0;
  end

  assign n_mem_oe     = ~(strobe & ~acc.n_r_read);
  assign n_mem_we     = ~(strobe & acc.n_r_read);
  assign mem_wdata_en = cs_active & acc.n_r_read;  // Drive bus for writes only

endmodule

/* design/smc_top.sv */
// Controller top level, plain host and memory pins around decode, execute and result stages
`include "smc_defs.svh"

module smc_top
(
  input  logic                       sys_clk30,
  input  logic                       n_sys_reset30,
  // Host port
  input  logic                       req,
  input  logic                       write,
  input  smc_pkg::host_addr_t        addr,
  input  smc_pkg::xfer_size_t        size,
  input  smc_pkg::host_data_t        wdata,
  output logic                       accept,
  output logic                       done,
  output smc_pkg::host_data_t        rdata,
  output logic                       idle,
  // Memory bus
  output logic [`SMC_NUM_BANKS-1:0]  n_mem_cs,
  output logic                       n_mem_oe,
  output logic                       n_mem_we,
  output smc_pkg::host_addr_t        mem_addr,
  output smc_pkg::mem_data_t         mem_wdata,
  input  smc_pkg::mem_data_t         mem_rdata,
  output logic                       mem_wdata_en
);

  smc_pkg::smc_state_e   r_smc_currentstate;
  smc_pkg::edge_count_t  r_csle_count;
  smc_pkg::edge_count_t  r_cste_count;
  smc_pkg::ws_count_t    r_ws_count;
  logic                  le_enable;
  logic                  ws_enable;
  logic                  cste_enable;
  logic                  smc_done;
  logic                  latch_data;
  logic                  mac_done;

  smc_access_if acc ();

  smc_access_decode decode0
  (
    .sys_clk30     (sys_clk30),
    .n_sys_reset30 (n_sys_reset30),
    .req           (req),
    .write         (write),
    .addr          (addr),
    .size          (size),
    .wdata         (wdata),
    .valid_access  (accept),
    .acc           (acc)
  );

  smc_counters counters0
  (
    .sys_clk30     (sys_clk30),
    .n_sys_reset30 (n_sys_reset30),
    .acc           (acc),
    .le_enable     (le_enable),
    .ws_enable     (ws_enable),
    .cste_enable   (cste_enable),
    .valid_access  (accept),
    .r_csle_count  (r_csle_count),
    .r_cste_count  (r_cste_count),
    .r_ws_count    (r_ws_count)
  );

  smc_state state0
  (
    .sys_clk30          (sys_clk30),
    .n_sys_reset30      (n_sys_reset30),
    .acc                (acc),
    .r_csle_count       (r_csle_count),
    .r_cste_count       (r_cste_count),
    .r_ws_count         (r_ws_count),
    .mac_done           (mac_done),
    .r_smc_currentstate (r_smc_currentstate),
    .smc_nextstate      (),
    .cste_enable        (cste_enable),
    .ws_enable          (ws_enable),
    .le_enable          (le_enable),
    .smc_done           (smc_done),
    .valid_access       (accept),
    .latch_data         (latch_data),
    .smc_idle           (idle)
  );

  smc_mac_data mac0
  (
    .sys_clk30          (sys_clk30),
    .n_sys_reset30      (n_sys_reset30),
    .acc                (acc),
    .r_smc_currentstate (r_smc_currentstate),
    .smc_done           (smc_done),
    .latch_data         (latch_data),
    .valid_access       (accept),
    .mac_done           (mac_done),
    .done               (done),
    .rdata              (rdata),
    .n_mem_cs           (n_mem_cs),
    .n_mem_oe           (n_mem_oe),
    .n_mem_we           (n_mem_we),
    .mem_wdata_en       (mem_wdata_en),
    .mem_addr           (mem_addr),
    .mem_wdata          (mem_wdata),
    .mem_rdata          (mem_rdata)
  );

endmodule

/* tests/smc_asserts.sv */
// Concurrent checks on memory strobes and FSM phases, bound into the result stage of the DUT
`include "smc_defs.svh"

module smc_asserts
(
  input logic                       sys_clk30,
  input logic                       n_sys_reset30,
  input smc_pkg::smc_state_e        r_smc_currentstate,
  input logic                       smc_done,
  input logic                       valid_access,
  input logic                       done,
  input logic [`SMC_NUM_BANKS-1:0]  n_mem_cs,
  input logic                       n_mem_oe,
  input logic                       n_mem_we
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------------------------------------
  // Memory bus rules
  // ------------------------------------------------------------
  // One bank at most, and never a hop from one bank straight to the other
  one_cs: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
    $onehot0(~n_mem_cs) &&
    ((n_mem_cs == '1) || ($past(n_mem_cs) == '1) || (n_mem_cs == $past(n_mem_cs))))
    else $error("More than one chip select low or bank changed without a gap");

  // Strobes never overlap and a direction flip needs a gap
  oe_we_apart: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
    !(!n_mem_oe && !n_mem_we) &&
    !(!n_mem_oe && !$past(n_mem_we)) && !(!n_mem_we && !$past(n_mem_oe)))
    else $error("Output and write enable low together or back to back");

  // ------------------------------------------------------------
  // FSM rules
  // ------------------------------------------------------------
  done_phase: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
    smc_done |-> (r_smc_currentstate == smc_pkg::st_rw ||
                  r_smc_currentstate == smc_pkg::st_float) && (n_mem_cs != '1))
    else $error("Beat done outside strobe or float, or with no chip select low");

  // Request taken mid-access ends that access, host sees done next cycle
  accept_point: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
    valid_access && (r_smc_currentstate != smc_pkg::st_idle) |=> done)
    else $error("Request taken before the last beat ended");

endmodule

bind smc_mac_data smc_asserts asserts0
(
  .sys_clk30          (sys_clk30),
  .n_sys_reset30      (n_sys_reset30),
  .r_smc_currentstate (r_smc_currentstate),
  .smc_done           (smc_done),
  .valid_access       (valid_access),
  .done               (done),
  .n_mem_cs           (n_mem_cs),
  .n_mem_oe           (n_mem_oe),
  .n_mem_we           (n_mem_we)
);

/* tests/smc_tb.sv */
// Testbench for the memory controller, drives random host traffic and checks it against a byte model
`include "smc_defs.svh"

module smc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 100;
  localparam int ACCEPT_LIMIT = 200;  // Cycles a request may wait
  localparam int DRAIN_LIMIT  = 500;
  localparam int NUM_FILL     = 16;   // Writes, then reads of the same spots
  localparam int NUM_MIXED    = 32;

  typedef struct packed
  {
    logic                 write;
    smc_pkg::host_addr_t  addr;
    smc_pkg::xfer_size_t  size;
    smc_pkg::host_data_t  wdata;
    smc_pkg::host_data_t  exp;  // Expected read word, valid lanes only
  } txn_t;

  logic                 sys_clk30;
  logic                 n_sys_reset30;
  logic                 req;
  logic                 write;
  smc_pkg::host_addr_t  addr;
  smc_pkg::xfer_size_t  size;
  smc_pkg::host_data_t  wdata;
  logic                 accept;
  logic                 done;
  smc_pkg::host_data_t  rdata;
  logic                 idle;
  logic [1:0]           n_mem_cs;
  logic                 n_mem_oe;
  logic                 n_mem_we;
  smc_pkg::host_addr_t  mem_addr;
  smc_pkg::mem_data_t   mem_wdata;
  smc_pkg::mem_data_t   mem_rdata;
  logic                 mem_wdata_en;

  smc_pkg::mem_data_t   mem [0:65535];      // External part
  smc_pkg::mem_data_t   ref_mem [0:65535];  // Reference copy
  txn_t                 q[$];               // Accepted, waiting for done
  txn_t                 fill_txn [0:NUM_FILL-1];
  logic [15:0]          lfsr_state;
  int                   error_count;
  int                   pulses;             // Strobes of front transfer
  int                   low_count;          // Width of current strobe
  int                   wait_cycles;
  logic                 strobe_prev;
  logic                 pulse_bank;
  logic                 we_prev;
  smc_pkg::host_addr_t  wr_addr;
  smc_pkg::mem_data_t   wr_data;

  smc_top dut0
  (
    .sys_clk30 (sys_clk30), .n_sys_reset30 (n_sys_reset30),
    .req (req), .write (write), .addr (addr), .size (size), .wdata (wdata),
    .accept (accept), .done (done), .rdata (rdata), .idle (idle),
    .n_mem_cs (n_mem_cs), .n_mem_oe (n_mem_oe), .n_mem_we (n_mem_we),
    .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_rdata (mem_rdata),
    .mem_wdata_en (mem_wdata_en)
  );

  initial
  begin
    sys_clk30 = 1'b0;
    forever
      #(CLK_PERIOD/2) sys_clk30 = ~sys_clk30;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic smc_pkg::mem_data_t fill_byte(input smc_pkg::host_addr_t a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'ha5;  // Whole address folded in
  endfunction

  function automatic int beats_of(input smc_pkg::xfer_size_t s);
    return (s == 2'd0) ? 1 : ((s == 2'd1) ? 2 : 4);
  endfunction

  function automatic int ws_of(input logic bank);
    return bank ? `SMC_B1_WS : `SMC_B0_WS;
  endfunction

  // Generous bound, every beat may also float
  function automatic int done_limit(input txn_t t);
    int per_beat;
    per_beat = t.addr[`SMC_BANK_SEL_BIT] ?
               (`SMC_B1_CSLE + `SMC_B1_WS + `SMC_B1_CSTE + 3) :
               (`SMC_B0_CSLE + `SMC_B0_WS + `SMC_B0_CSTE + 3);
    return 8 + beats_of(t.size) * per_beat;
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // Galois, x^16+x^14+x^13+x^11+1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};  // One step per bit
    end
  endtask

  task automatic stop_with_failure(input string why);
    error_count++;
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
    stop_with_failure($sformatf("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_idle_pins();
    assert (n_mem_cs == 2'b11) else value_fail("n_mem_cs", 32'(n_mem_cs), 32'h3);
    assert (n_mem_oe && n_mem_we) else stop_with_failure("Strobe low while idle after reset");
    assert (!accept && !done) else stop_with_failure("accept or done high during reset");
    assert (idle && !mem_wdata_en) else stop_with_failure("idle low or bus driven during reset");
  endtask

  task automatic make_txn(input logic wr, output txn_t t);
    logic [31:0] r;
    t.write = wr;
    rand_bits(5, r);  // Bank bit and word index
    t.addr = {r[4], 9'd0, r[3:0], 2'b00};
    rand_bits(2, r);
    t.size = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
    rand_bits(32, r);
    t.wdata = r;
    t.exp = '0;
  endtask

  // Holds the request until accept, then updates the reference in order
  task automatic issue(input txn_t t);
    int    waited;
    logic  busy;  // Previous access still running at accept
    waited = 0;
    req   = 1'b1;
    write = t.write;
    addr  = t.addr;
    size  = t.size;
    wdata = t.wdata;
    #(CLK_PERIOD/4);  // Accept settles well before the rising edge
    while (accept !== 1'b1)
    begin
      if (waited > ACCEPT_LIMIT)
        stop_with_failure("Request was never accepted");
      // Held request must be taken in the cycle the running access ends
      assert (waited == 0 || !done)
        else stop_with_failure("Held request was not taken when the previous access ended");
      @(negedge sys_clk30);
      #(CLK_PERIOD/4);
      waited++;
    end
    busy = (q.size() > 0);
    for (int i = 0; i < beats_of(t.size); i++)
    begin
      if (t.write)
        ref_mem[t.addr + 16'(i)] = t.wdata[8*i +: 8];
      else
        t.exp[8*i +: 8] = ref_mem[t.addr + 16'(i)];
    end
    q.push_back(t);
    @(negedge sys_clk30);
    if (busy)
      assert (done) else stop_with_failure("Request taken before the previous access ended");
  endtask

  // ------------------------------------------------------------
  // Memory model, write lands once the strobe has risen
  // ------------------------------------------------------------
  assign mem_rdata = !n_mem_oe ? mem[mem_addr] : 8'h00;

  always @(negedge sys_clk30)
  begin
    if (!n_mem_we)
    begin
      wr_addr = mem_addr;
      wr_data = mem_wdata;
    end
    else if (!we_prev)
      mem[wr_addr] = wr_data;
    we_prev = n_mem_we;
  end

  // ------------------------------------------------------------
  // Bus and completion monitor
  // ------------------------------------------------------------
  always @(negedge sys_clk30)
  begin
    txn_t  cur;
    logic  strobe_low;
    strobe_low = !n_mem_oe || !n_mem_we;
    if (n_sys_reset30)
    begin
      if (done)
      begin
        assert (q.size() > 0) else stop_with_failure("done without an accepted request");
        cur = q.pop_front();
        assert (pulses == beats_of(cur.size)) else value_fail("strobe pulses", 32'(pulses),
                                                              32'(beats_of(cur.size)));
        if (!cur.write)
          assert ((rdata & (32'hffffffff >> (32 - 8*beats_of(cur.size)))) == cur.exp)
            else value_fail("rdata", rdata, cur.exp);
        pulses      = 0;
        wait_cycles = 0;
      end
      else if (q.size() > 0)
      begin
        wait_cycles++;
        assert (wait_cycles <= done_limit(q[0])) else stop_with_failure("No done within timeout");
      end
      if (strobe_low && !strobe_prev)  // Beat starts
      begin
        assert (q.size() > 0) else stop_with_failure("Strobe without an accepted request");
        cur = q[0];
        assert (mem_addr == cur.addr + 16'(pulses)) else value_fail("mem_addr", 32'(mem_addr),
                                                                    32'(cur.addr + 16'(pulses)));
        assert (n_mem_cs == ~(2'b01 << cur.addr[`SMC_BANK_SEL_BIT]))
          else value_fail("n_mem_cs", 32'(n_mem_cs), 32'(~(2'b01 << cur.addr[15])));
        assert (n_mem_we == !cur.write) else value_fail("n_mem_we", 32'(n_mem_we), 32'(!cur.write));
        if (cur.write)
          assert (mem_wdata == cur.wdata[8*pulses +: 8] && mem_wdata_en)
            else value_fail("mem_wdata", 32'(mem_wdata), 32'(cur.wdata[8*pulses +: 8]));
        pulse_bank = cur.addr[`SMC_BANK_SEL_BIT];
        low_count  = 0;
        pulses++;
      end
      if (strobe_low)
        low_count++;
      else if (strobe_prev)  // Strobe just ended
        assert (low_count == ws_of(pulse_bank) + 1)
          else value_fail("strobe width", 32'(low_count), 32'(ws_of(pulse_bank) + 1));
    end
    strobe_prev = strobe_low;
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial
  begin
    txn_t         t;
    logic [31:0]  r;
    int           drain;
    n_sys_reset30 = 1'b0;
    req           = 1'b0;
    write         = 1'b0;
    addr          = '0;
    size          = '0;
    wdata         = '0;
    lfsr_state    = 16'd25;
    error_count   = 0;
    pulses        = 0;
    low_count     = 0;
    wait_cycles   = 0;
    strobe_prev   = 1'b0;
    pulse_bank    = 1'b0;
    we_prev       = 1'b1;
    for (int a = 0; a < 65536; a++)
    begin
      mem[a]     = fill_byte(16'(a));
      ref_mem[a] = fill_byte(16'(a));
    end

    repeat (16)
    begin
      @(negedge sys_clk30);
      check_idle_pins();
    end
    n_sys_reset30 = 1'b1;
    @(negedge sys_clk30);
    check_idle_pins();

    // Writes back to back, then the same spots read back
    for (int k = 0; k < NUM_FILL; k++)
    begin
      make_txn(1'b1, fill_txn[k]);
      issue(fill_txn[k]);
    end
    for (int k = 0; k < NUM_FILL; k++)
    begin
      t = fill_txn[k];
      t.write = 1'b0;
      issue(t);
    end

    // Mixed direction and bank, sometimes with a gap
    for (int k = 0; k < NUM_MIXED; k++)
    begin
      rand_bits(1, r);
      make_txn(r[0], t);
      issue(t);
      rand_bits(2, r);
      if (r[1:0] == 2'd0)
      begin
        req = 1'b0;
        @(negedge sys_clk30);
      end
    end
    req = 1'b0;

    drain = 0;
    while (q.size() > 0)
    begin
      if (drain > DRAIN_LIMIT)
        stop_with_failure("Outstanding requests never completed");
      @(negedge sys_clk30);
      drain++;
    end
    @(negedge sys_clk30);
    assert (idle) else stop_with_failure("Controller not idle after the last done");

    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* src.f */
+incdir+design
design/smc_pkg.sv
design/smc_access_if.sv
design/smc_access_decode.sv
design/smc_counters.sv
design/smc_state.sv
design/smc_mac_data.sv
design/smc_top.sv
tests/smc_asserts.sv
tests/smc_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module smc_tb -f src.f -o Vsmc_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vsmc_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

exit 0
